/* agnus_pkg.sv */
package agnus_pkg;

	// --------------------
	// bus word types
	// --------------------

	typedef logic [20:1] chip_addr_t;	// chip ram word address
	typedef logic [8:1] reg_addr_t;		// custom register word address

	// one dma channel request as it arrives from its engine
	typedef struct packed {
		logic		req;			// channel wants this slot
		logic		we;				// memory write, only disk and blitter use it
		chip_addr_t	address;		// chip ram word address
		reg_addr_t	reg_address;	// destination or source register
	} dma_chan_t;

	// cpu side of the register bank
	typedef struct packed {
		logic		aen;			// register bank selected
		logic		rd;				// read strobe
		logic		hwr;			// high byte write
		logic		lwr;			// low byte write
		reg_addr_t	address;
	} cpu_bus_t;

	// the bus as driven after arbitration
	typedef struct packed {
		logic		dbr;			// agnus owns the data bus
		logic		dbwe;			// agnus memory write cycle
		chip_addr_t	address;
		reg_addr_t	reg_address;
	} chip_bus_t;

	// acks for channels that can be held off
	typedef struct packed {
		logic	spr;
		logic	cop;
		logic	blt;
	} dma_ack_t;

	// enables decoded from dmacon
	typedef struct packed {
		logic	bltpri;		// blitter nasty
		logic	bplen;
		logic	copen;
		logic	blten;
		logic	spren;
	} dma_enables_t;

	// dmacon as written through DMACON and read back through DMACONR
	typedef union packed {
		struct packed {
			logic			setclr;	// 1 sets the mask bits, 0 clears them
			logic	[1:0]	unused;
			logic	[12:0]	mask;
		} wr;
		struct packed {
			logic			zero;
			logic			bbusy;	// blitter busy
			logic			bzero;	// blitter zero flag
			logic	[12:0]	dmacon;
		} rd;
	} dmacon_word_u;

	// --------------------
	// constants
	// --------------------

	localparam reg_addr_t REG_DMACON = reg_addr_t'(9'h096 >> 1);	// word address
	localparam reg_addr_t REG_DMACONR = reg_addr_t'(9'h002 >> 1);
	localparam reg_addr_t REG_IDLE = 8'hFF;		// nothing addressed

	localparam logic [8:0] REFRESH_FIRST = 9'd1;	// odd slot, chipset side
	localparam logic [8:0] REFRESH_COUNT = 9'd4;	// spaced two slots apart

	localparam logic [1:0] BLS_CNT_MAX = 2'd3;	// missed cpu cycles before blitter stops

endpackage

/* agnus_hcounter.sv */
`timescale 1ns/10ps

// horizontal slot counter
// one count per bus slot, odd counts are colour clock slots used by the chipset
module agnus_hcounter import agnus_pkg::*;
#(
	parameter int LINE_CYCLES = 454	// slots per line, at least 10 and at most 512
)
(
	input	logic			clk,
	input	logic			reset,
	output	logic	[8:0]	hpos,		// current slot
	output	logic			refresh,	// memory refresh slot
	output	logic			sol		// last slot of the line
);

	// --------------------
	// decode limits
	// --------------------

	localparam logic [8:0] LAST_SLOT = 9'(LINE_CYCLES - 1);

	// first slot past the refresh group
	localparam logic [8:0] REFRESH_END = REFRESH_FIRST + (REFRESH_COUNT << 1);

	logic	in_refresh_range;	// inside first..last refresh slot
	logic	refresh_parity;		// same parity as the first refresh slot

	// --------------------
	// counter
	// --------------------

	always_ff @(posedge clk)
	begin
		if (reset)
			hpos <= 9'd0;
		else if (hpos == LAST_SLOT)
			hpos <= 9'd0;			// wrap at end of line
		else
			hpos <= hpos + 9'd1;
	end

	// --------------------
	// slot decode
	// --------------------

	// refresh takes every other slot starting at REFRESH_FIRST
	assign in_refresh_range = (hpos >= REFRESH_FIRST) && (hpos < REFRESH_END);
	assign refresh_parity = (hpos[0] == REFRESH_FIRST[0]);
	assign refresh = in_refresh_range && refresh_parity;

	// high during the last slot, so the next edge starts a line
	assign sol = (hpos == LAST_SLOT);

endmodule

/* agnus_dmacon.sv */
`timescale 1ns/10ps

// DMACON register with set/clear write and DMACONR readback
module agnus_dmacon import agnus_pkg::*;
(
	input	logic			clk,
	input	logic			reset,
	input	reg_addr_t		reg_address,	// final address after arbitration
	input	logic	[15:0]	data_in,		// register write data
	input	logic			blit_busy,		// blitter status from the engine
	input	logic			blit_zero,
	output	logic	[15:0]	data_out,		// DMACONR or zero
	output	dma_enables_t	en				// decoded channel enables
);

	// dmacon bit positions
	localparam int BIT_BLTPRI = 10;	// blitter nasty
	localparam int BIT_DMAEN = 9;		// master enable
	localparam int BIT_BPLEN = 8;
	localparam int BIT_COPEN = 7;
	localparam int BIT_BLTEN = 6;
	localparam int BIT_SPREN = 5;

	logic	[12:0]	dmacon;		// the control register itself
	dmacon_word_u	wr_word;	// incoming write, seen through the write view
	dmacon_word_u	rd_word;	// DMACONR word, built through the read view
	logic			wr_hit;		// register write addressed to DMACON
	logic			rd_hit;		// read address is DMACONR

	assign wr_hit = (reg_address == REG_DMACON);
	assign rd_hit = (reg_address == REG_DMACONR);

	// --------------------
	// write
	// --------------------

	assign wr_word = data_in;

	always_ff @(posedge clk)
	begin
		if (reset)
			dmacon <= 13'd0;
		else if (wr_hit)
		begin
			if (wr_word.wr.setclr)
				dmacon <= dmacon | wr_word.wr.mask;		// set the masked bits
			else
				dmacon <= dmacon & ~wr_word.wr.mask;	// clear the masked bits
		end
	end

	// --------------------
	// read
	// --------------------

	assign rd_word.rd = '{zero: 1'b0, bbusy: blit_busy, bzero: blit_zero, dmacon: dmacon};

	// zero when not addressed so it can be or-ed with other read sources
	assign data_out = rd_hit ? rd_word : 16'h0000;

	// --------------------
	// enables
	// --------------------

	assign en.bltpri = dmacon[BIT_BLTPRI];		// not gated by master
	assign en.bplen = dmacon[BIT_BPLEN] & dmacon[BIT_DMAEN];
	assign en.copen = dmacon[BIT_COPEN] & dmacon[BIT_DMAEN];
	assign en.blten = dmacon[BIT_BLTEN] & dmacon[BIT_DMAEN];
	assign en.spren = dmacon[BIT_SPREN] & dmacon[BIT_DMAEN];

endmodule

/* agnus_dma_arbiter.sv */
`timescale 1ns/10ps

// chip bus arbiter
// fixed priority, first active source takes the slot, the cpu gets what is left
// disk, audio and bitplane own their slot outright
// sprite, copper and blitter transfer on the edge where ack is high
module agnus_dma_arbiter import agnus_pkg::*;
(
	input	logic			clk,
	input	logic			reset,
	input	logic	[8:0]	hpos,		// slot counter, odd slots are cck
	input	logic			refresh,	// refresh slot from the counter
	input	dma_chan_t		disk,
	input	dma_chan_t		audio,
	input	dma_chan_t		bitplane,
	input	dma_chan_t		sprite,
	input	dma_chan_t		copper,
	input	dma_chan_t		blitter,
	input	cpu_bus_t		cpu,		// cpu register access
	input	dma_enables_t	en,			// dmacon enables
	input	logic			bls,		// cpu is waiting for the bus
	input	logic			turbo,		// blitter may use every slot
	output	chip_bus_t		bus,
	output	dma_ack_t		ack
);

	// refresh cycle, no register and no write
	localparam chip_bus_t REFRESH_BUS = '{
		dbr: 1'b1,
		dbwe: 1'b0,
		address: '0,
		reg_address: REG_IDLE
	};

	logic	[1:0]	bls_cnt;		// counted cycles the cpu missed the bus
	logic			bls_block;		// counter at limit, blitter held off
	logic			bls_tick;		// counter update slot
	logic			bpl_req;		// requests after dmacon gating
	logic			spr_req;
	logic			cop_req;
	logic			blt_req;
	logic			cpu_access;		// cpu strobe present
	reg_addr_t		cpu_reg_address;
	chip_bus_t		idle_bus;		// bus when no channel is granted

	// bus word for a granted channel
	// wr_ok is set only for channels that are allowed to write memory
	function automatic chip_bus_t chan_bus(input dma_chan_t ch, input logic wr_ok);
		chip_bus_t b;
		b.dbr = 1'b1;
		b.dbwe = ch.we & wr_ok;
		b.address = ch.address;
		b.reg_address = ch.reg_address;
		return b;
	endfunction

	// --------------------
	// request gating
	// --------------------

	// disk and audio engines gate themselves
	assign bpl_req = bitplane.req & en.bplen;
	assign spr_req = sprite.req & en.spren;
	assign cop_req = copper.req & en.copen;
	assign blt_req = blitter.req & en.blten;

	assign bls_block = (bls_cnt == BLS_CNT_MAX);

	// cpu register address only while it strobes, idle otherwise
	assign cpu_access = cpu.aen & (cpu.rd | cpu.hwr | cpu.lwr);
	assign cpu_reg_address = cpu_access ? cpu.address : REG_IDLE;

	assign idle_bus = '{dbr: 1'b0, dbwe: 1'b0, address: '0, reg_address: cpu_reg_address};

	// --------------------
	// priority mux
	// --------------------

	always_comb
	begin
		bus = idle_bus;				// cpu slot unless a channel wins
		ack = '0;
		if (disk.req)
			bus = chan_bus(disk, 1'b1);			// disk may write memory
		else if (refresh)
			bus = REFRESH_BUS;
		else if (audio.req)
			bus = chan_bus(audio, 1'b0);
		else if (bpl_req)
			bus = chan_bus(bitplane, 1'b0);
		else if (spr_req)
		begin
			bus = chan_bus(sprite, 1'b0);
			ack.spr = 1'b1;
		end
		else if (cop_req)
		begin
			bus = chan_bus(copper, 1'b0);
			ack.cop = 1'b1;
		end
		else if (blt_req && !bls_block)
		begin
			bus = chan_bus(blitter, 1'b1);	// blitter may write memory
			ack.blt = 1'b1;
		end
	end

	// --------------------
	// blitter slowdown
	// --------------------

	// counts on even slots, or every slot in turbo
	assign bls_tick = ~hpos[0] | turbo;

	always_ff @(posedge clk)
	begin
		if (reset)
			bls_cnt <= 2'd0;
		else if (bls_tick)
		begin
			if (!bls || en.bltpri)
				bls_cnt <= 2'd0;				// cpu got the bus or nasty mode
			else if (!bls_block)
				bls_cnt <= bls_cnt + 2'd1;	// stops at the limit
		end
	end

endmodule

/* agnus_bus.sv */
`timescale 1ns/10ps

// agnus chip bus
// slot counter, dmacon and arbiter, dma engines sit outside
module agnus_bus import agnus_pkg::*;
#(
	parameter int LINE_CYCLES = 454	// slots per line
)
(
	input	logic			clk,
	input	logic			reset,

	// cpu register access
	input	cpu_bus_t		cpu,
	input	logic	[15:0]	data_in,

	// dma channel requests
	input	dma_chan_t		disk,
	input	dma_chan_t		audio,
	input	dma_chan_t		bitplane,
	input	dma_chan_t		sprite,
	input	dma_chan_t		copper,
	input	dma_chan_t		blitter,

	// blitter status and bus sharing
	input	logic			blit_busy,
	input	logic			blit_zero,
	input	logic			bls,		// cpu missed the bus
	input	logic			turbo,

	output	chip_bus_t		bus,		// granted bus
	output	dma_ack_t		ack,		// sprite, copper, blitter acks
	output	logic	[15:0]	data_out,	// DMACONR readback
	output	logic			sol			// last slot of line
);

	logic	[8:0]	hpos;		// bus slot
	logic			refresh;	// refresh slot
	dma_enables_t	en;			// dmacon enables to the arbiter

	// --------------------
	// slot counter
	// --------------------

	agnus_hcounter #(
		.LINE_CYCLES(LINE_CYCLES)
	) u_hcounter (
		.clk(clk),
		.reset(reset),
		.hpos(hpos),
		.refresh(refresh),
		.sol(sol)
	);

	// --------------------
	// control register
	// --------------------

	// decodes on the arbitrated register address, not the raw cpu one
	agnus_dmacon u_dmacon (
		.clk(clk),
		.reset(reset),
		.reg_address(bus.reg_address),
		.data_in(data_in),
		.blit_busy(blit_busy),
		.blit_zero(blit_zero),
		.data_out(data_out),
		.en(en)
	);

	// --------------------
	// arbiter
	// --------------------

	agnus_dma_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.hpos(hpos),
		.refresh(refresh),
		.disk(disk),
		.audio(audio),
		.bitplane(bitplane),
		.sprite(sprite),
		.copper(copper),
		.blitter(blitter),
		.cpu(cpu),
		.en(en),
		.bls(bls),
		.turbo(turbo),
		.bus(bus),
		.ack(ack)
	);

endmodule

/* agnus_dma_arbiter_asserts.sv */
`timescale 1ns/10ps

// concurrent checks on the chip bus arbiter, bound into every arbiter instance
module agnus_dma_arbiter_asserts import agnus_pkg::*;
(
	input	logic			clk,
	input	logic			reset,
	input	chip_bus_t		bus,		// granted bus
	input	dma_ack_t		ack,
	input	logic	[1:0]	bls_cnt		// slowdown counter inside the arbiter
);

	int unsigned	fail_count = 0;	// failures so far, read by the testbench at the end

	// ---------------------
	// only one held-off channel transfers per slot
	one_ack: assert property (@(posedge clk) disable iff (reset)
		$onehot0({ack.spr, ack.cop, ack.blt}))
	else
	begin
		$error("more than one ack high in the same slot");
		fail_count++;
	end

	// a memory write needs the bus
	write_owns_bus: assert property (@(posedge clk) disable iff (reset) bus.dbwe |-> bus.dbr)
	else
	begin
		$error("dbwe high without dbr");
		fail_count++;
	end

	// blitter held off at the slowdown limit
	blt_blocked: assert property (@(posedge clk) disable iff (reset)
		(bls_cnt == BLS_CNT_MAX) |-> !ack.blt)
	else
	begin
		$error("blitter acknowledged with the slowdown counter at its limit");
		fail_count++;
	end

endmodule

bind agnus_dma_arbiter agnus_dma_arbiter_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.bus(bus),
	.ack(ack),
	.bls_cnt(bls_cnt)
);

/* tb_agnus_bus.sv */
`timescale 1ns/10ps

// testbench for the agnus chip bus, directed tests on a short line
module tb_agnus_bus import agnus_pkg::*;
();

	localparam int LINE_CYCLES = 64;
	localparam logic [8:0] LAST_SLOT = 9'(LINE_CYCLES - 1);
	// slots per test, writes may wait out a refresh group
	localparam int TOTAL_CYCLES = 10 + 70 + 2 * LINE_CYCLES + 210 + 130 + 110 + 2 * LINE_CYCLES;

	logic			clk = 1'b0;
	logic			reset;
	cpu_bus_t		cpu;
	logic	[15:0]	data_in;
	dma_chan_t		disk, audio, bitplane, sprite, copper, blitter;
	logic			blit_busy, blit_zero, bls, turbo;
	chip_bus_t		bus;
	dma_ack_t		ack;
	logic	[15:0]	data_out;
	logic			sol;

	logic	[8:0]	m_hpos;		// slot model, counted from reset
	logic	[12:0]	m_dmacon;	// register model, follows our own writes
	logic	[1:0]	m_bls_cnt;	// slowdown counter model
	logic	[31:0]	rng = 32'd81690;
	int				errors = 0;
	int				tests_passed = 0;
	int				tests_failed = 0;
	int				refused;	// blitter slots lost to the slowdown

	agnus_bus #(.LINE_CYCLES(LINE_CYCLES)) dut (.*);

	always #10 clk = ~clk;	// 20 ns slot

	always @(posedge clk)
		m_hpos <= (reset || m_hpos == LAST_SLOT) ? 9'd0 : m_hpos + 9'd1;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// odd slots from REFRESH_FIRST, REFRESH_COUNT of them
	function automatic logic slot_is_refresh(input logic [8:0] h);
		return h >= REFRESH_FIRST && h < REFRESH_FIRST + 2 * REFRESH_COUNT && h[0] == REFRESH_FIRST[0];
	endfunction

	function automatic dma_enables_t model_enables();
		dma_enables_t e;
		e.bltpri = m_dmacon[10];				// ungated
		e.bplen = m_dmacon[8] & m_dmacon[9];	// 9 is the master bit
		e.copen = m_dmacon[7] & m_dmacon[9];
		e.blten = m_dmacon[6] & m_dmacon[9];
		e.spren = m_dmacon[5] & m_dmacon[9];
		return e;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else
		begin
			$display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
			errors++;
		end
	endtask

	// counter rule on the values held this slot, then on to 2 ns past the edge
	task automatic next_slot();
		if (reset)
			m_bls_cnt = 2'd0;
		else if (!m_hpos[0] || turbo)
		begin
			if (!bls || m_dmacon[10])
				m_bls_cnt = 2'd0;
			else if (m_bls_cnt != BLS_CNT_MAX)
				m_bls_cnt = m_bls_cnt + 2'd1;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic clear_inputs();
		cpu = '0;
		data_in = 16'h0000;		// zero data keeps stray DMACON hits harmless
		{disk, audio, bitplane, sprite, copper, blitter} = '0;
		{blit_busy, blit_zero, bls, turbo} = 4'b0000;
	endtask

	// cpu register write, kept off refresh slots where the cpu loses the address
	task automatic cpu_write(input reg_addr_t a, input logic [15:0] d);
		while (slot_is_refresh(m_hpos))
			next_slot();
		cpu = '{aen: 1'b1, rd: 1'b0, hwr: 1'b1, lwr: 1'b1, address: a};
		data_in = d;
		next_slot();
		if (a == REG_DMACON)
			m_dmacon = d[15] ? (m_dmacon | d[12:0]) : (m_dmacon & ~d[12:0]);
		cpu = '0;
		data_in = 16'h0000;
	endtask

	task automatic read_dmaconr();
		while (slot_is_refresh(m_hpos))
			next_slot();
		cpu = '{aen: 1'b1, rd: 1'b1, hwr: 1'b0, lwr: 1'b0, address: REG_DMACONR};
		#5;
		check_value("data_out", 32'({1'b0, blit_busy, blit_zero, m_dmacon}), 32'(data_out));
		next_slot();
		cpu = '0;
	endtask

	// expected owner from the priority list, compared field by field
	task automatic check_grant();
		chip_bus_t		exp_bus;
		dma_ack_t		exp_ack;
		dma_enables_t	e;
		logic			cpu_on;
		#5;
		e = model_enables();
		cpu_on = cpu.aen && (cpu.rd || cpu.hwr || cpu.lwr);
		exp_bus = '{1'b0, 1'b0, 20'h0, cpu_on ? cpu.address : REG_IDLE};
		exp_ack = '0;
		if (disk.req)
			exp_bus = '{1'b1, disk.we, disk.address, disk.reg_address};
		else if (slot_is_refresh(m_hpos))
			exp_bus = '{1'b1, 1'b0, 20'h0, REG_IDLE};
		else if (audio.req)
			exp_bus = '{1'b1, 1'b0, audio.address, audio.reg_address};
		else if (bitplane.req && e.bplen)
			exp_bus = '{1'b1, 1'b0, bitplane.address, bitplane.reg_address};
		else if (sprite.req && e.spren)
		begin
			exp_bus = '{1'b1, 1'b0, sprite.address, sprite.reg_address};
			exp_ack.spr = 1'b1;
		end
		else if (copper.req && e.copen)
		begin
			exp_bus = '{1'b1, 1'b0, copper.address, copper.reg_address};
			exp_ack.cop = 1'b1;
		end
		else if (blitter.req && e.blten && m_bls_cnt != BLS_CNT_MAX)
		begin
			exp_bus = '{1'b1, blitter.we, blitter.address, blitter.reg_address};
			exp_ack.blt = 1'b1;
		end
		check_value("bus.dbr", 32'(exp_bus.dbr), 32'(bus.dbr));
		check_value("bus.dbwe", 32'(exp_bus.dbwe), 32'(bus.dbwe));
		check_value("bus.address", 32'(exp_bus.address), 32'(bus.address));
		check_value("bus.reg_address", 32'(exp_bus.reg_address), 32'(bus.reg_address));
		check_value("ack", 32'(exp_ack), 32'(ack));
	endtask

	task automatic random_chan(output dma_chan_t c);
		logic [31:0] r;
		next_random(r);
		c = '{req: r[1:0] == 2'b00, we: r[2], address: r[22:3], reg_address: r[30:23]};
	endtask

	// one slot of random requests and a random cpu access
	task automatic random_slot();
		logic [31:0] r;
		random_chan(disk);
		random_chan(audio);
		random_chan(bitplane);
		random_chan(sprite);
		random_chan(copper);
		random_chan(blitter);
		next_random(r);
		cpu = '{aen: r[0], rd: r[1], hwr: r[2], lwr: r[3], address: r[15:8]};
		check_grant();
		next_slot();
	endtask

	task automatic blit_slots(input int n);
		repeat (n)
		begin
			check_grant();
			if (!slot_is_refresh(m_hpos) && !ack.blt)
				refused++;
			next_slot();
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors)
		begin
			tests_passed++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	// ---------------------
	// directed tests
	// ---------------------

	task automatic dmacon_set_clear();
		int start;
		start = errors;
		blit_busy = 1'b1;
		cpu_write(REG_DMACON, 16'h87E0);	// master, bltpri, bpl, cop, blt, spr
		read_dmaconr();
		blit_busy = 1'b0;
		blit_zero = 1'b1;
		cpu_write(REG_DMACON, 16'h0520);	// drop bltpri, bpl, spr
		read_dmaconr();
		cpu = '{aen: 1'b1, rd: 1'b1, hwr: 1'b0, lwr: 1'b0, address: 8'h10};
		#5;
		check_value("data_out", 32'h0, 32'(data_out));	// other register reads as zero
		next_slot();
		cpu_write(REG_DMACON, 16'h7FFF);
		read_dmaconr();
		clear_inputs();
		finish_test("dmacon set/clear", start);
	endtask

	task automatic idle_and_refresh();
		int				start;
		logic	[31:0]	r;
		start = errors;
		repeat (2 * LINE_CYCLES)
		begin
			next_random(r);
			cpu = '{aen: r[1:0] != 2'b00, rd: r[1:0] != 2'b11, hwr: r[1:0] == 2'b11, lwr: 1'b0,
				address: r[15:8]};
			#5;
			check_value("bus.dbr", 32'(slot_is_refresh(m_hpos)), 32'(bus.dbr));
			check_value("bus.address", 32'h0, 32'(bus.address));
			if (slot_is_refresh(m_hpos) || !cpu.aen)
				check_value("bus.reg_address", 32'(REG_IDLE), 32'(bus.reg_address));
			else
				check_value("bus.reg_address", 32'(cpu.address), 32'(bus.reg_address));
			next_slot();
		end
		clear_inputs();
		finish_test("idle and refresh slots", start);
	endtask

	task automatic priority_order();
		int start;
		start = errors;
		cpu_write(REG_DMACON, 16'h83E0);	// master and every channel, no bltpri
		repeat (200)
			random_slot();
		clear_inputs();
		finish_test("priority order", start);
	endtask

	task automatic enable_gating();
		int start;
		start = errors;
		cpu_write(REG_DMACON, 16'h0200);	// master off, channel bits kept
		repeat (60)
			random_slot();
		clear_inputs();
		cpu_write(REG_DMACON, 16'h8200);
		cpu_write(REG_DMACON, 16'h01E0);	// master on, channel bits off
		repeat (60)
			random_slot();
		clear_inputs();
		finish_test("enable gating", start);
	endtask

	task automatic blitter_slowdown();
		int start;
		start = errors;
		refused = 0;
		cpu_write(REG_DMACON, 16'h7FFF);
		cpu_write(REG_DMACON, 16'h8240);	// master and blitter
		blitter = '{req: 1'b1, we: 1'b1, address: 20'h12345, reg_address: 8'h00};
		bls = 1'b1;
		blit_slots(16);
		assert (refused > 0)
		else
		begin
			$display("blitter was never refused while the cpu kept missing the bus");
			errors++;
		end
		blitter.req = 1'b0;
		cpu_write(REG_DMACON, 16'h8400);	// nasty mode
		blitter.req = 1'b1;
		blit_slots(12);
		blitter.req = 1'b0;
		cpu_write(REG_DMACON, 16'h0400);
		blitter.req = 1'b1;
		blit_slots(12);
		bls = 1'b0;		// cpu got the bus, counter clears
		blit_slots(6);
		bls = 1'b1;
		turbo = 1'b1;	// counts every slot
		blit_slots(10);
		clear_inputs();
		finish_test("blitter slowdown", start);
	endtask

	task automatic line_end();
		int start;
		int seen;
		start = errors;
		seen = 0;
		repeat (2 * LINE_CYCLES)
		begin
			#5;
			check_value("sol", 32'(m_hpos == LAST_SLOT), 32'(sol));
			seen += int'(sol);
			next_slot();
		end
		assert (seen == 2)
		else
		begin
			$display("sol was high on %0d slots over two lines instead of 2", seen);
			errors++;
		end
		finish_test("end of line", start);
	endtask

	initial
	begin
		reset = 1'b1;
		clear_inputs();
		m_dmacon = 13'd0;
		m_bls_cnt = 2'd0;
		repeat (10)
			next_slot();
		reset = 1'b0;
		dmacon_set_clear();
		idle_and_refresh();
		priority_order();
		enable_gating();
		blitter_slowdown();
		line_end();
		$display("tests passed %0d, tests failed %0d, bound assertion failures %0d",
			tests_passed, tests_failed, dut.u_arbiter.u_asserts.fail_count);
		if (tests_failed == 0 && dut.u_arbiter.u_asserts.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// watchdog, twice the slot budget of all tests
	initial
	begin
		#(TOTAL_CYCLES * 20 * 2);
		$display("timeout, the tests did not finish within %0d slots", 2 * TOTAL_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* tb.f */
agnus_pkg.sv
agnus_hcounter.sv
agnus_dmacon.sv
agnus_dma_arbiter.sv
agnus_bus.sv
agnus_dma_arbiter_asserts.sv
tb_agnus_bus.sv

/* run.sh */
#!/bin/sh
# build and run the agnus bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_agnus_bus -f tb.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# keep running past a failed concurrent check so the testbench can report it
out=$(./obj_dir/Vtb_agnus_bus +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
